// File: flist.f
verilog/wb_arb_pkg.sv
verilog/wb_arb_pending.sv
verilog/wb_arb_fsm.sv
verilog/wb_arb_mux.sv
verilog/wb_bus_timer.sv
verilog/wb_reg_slave.sv
verilog/wb_arb_top.sv
testbench/wb_arb_assert.sv
testbench/wb_arb_tb.sv

// File: testbench/wb_arb_assert.sv
`timescale 1ns/1ps

module wb_arb_assert
  import wb_arb_pkg::*;
(
  input logic                   wb_clk_i,
  input logic                   wb_rst_i,
  input logic [NUM_MASTERS-1:0] ack_i,
  input logic [NUM_MASTERS-1:0] err_i,
  input logic [MASTER_ID_W-1:0] id_i
);

  a_one_response: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    $onehot0({ack_i, err_i}))
    else $error("More than one ack or error bit is high");

  // The grant is held from the start of the slave cycle until its ack
  a_ack_to_grant: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (|ack_i) |-> (ack_i[id_i] && $stable(id_i)))
    else $error("Ack went to a master other than the one granted for the cycle");

  // Slave ack is a single-cycle pulse
  a_ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (|ack_i) |=> !(|ack_i))
    else $error("Ack high for two consecutive cycles");

endmodule

bind wb_arb_top wb_arb_assert wb_arb_assert_i (
  .wb_clk_i (wb_clk_i),
  .wb_rst_i (wb_rst_i),
  .ack_i    (wbm_ack_o),
  .err_i    (wbm_err_o),
  .id_i     (wbm_id_o)
);

// File: testbench/wb_arb_stimulus.txt
# req late mask we sel adr0 adr1 adr2 adr3 order err, all hex, sel has 2 bits per master
# late masters request 2 cycles after the start, order lists the first served master first
1 0 f 1 03 00000004 00000000 00000000 00000000 0 0
1 0 f 0 03 00000004 00000000 00000000 00000000 0 0
1 0 f 1 01 00000004 00000000 00000000 00000000 0 0
4 0 f 4 20 00000000 00000000 00000005 00000000 2 0
2 0 f 0 0c 00000000 00000004 00000000 00000000 1 0
f 0 f f ff 00000000 00000002 0000000c 0000001e 3210 0
f 0 f 0 ff 0000001e 0000000c 00000002 00000000 3210 0
f 0 7 0 ff 00000000 00000002 0000000c 0000001e 2103 0
5 0 a 5 33 0000000a 00000000 00000008 00000000 20 0
2 0 f 0 0c 00000000 00000100 00000000 00000000 1 2
2 0 f 2 0c 00000000 00000006 00000000 00000000 1 0
8 0 f 8 c0 00000000 00000000 00000000 80000004 3 8
1 0 f 0 03 00000004 00000000 00000000 00000000 0 0
1 e f 0 ff 00000000 00000002 0000000c 0000001e 0321 0
8 7 f 0 ff 00000004 00000006 00000008 00000020 3210 8
2 8 7 a cc 00000000 00000010 00000000 0000000e 13 0
f 0 f 0 ff 00000008 0000000e 00000010 0000000a 3210 0

// File: testbench/wb_arb_tb.sv
`timescale 1ns/1ps

module wb_arb_tb
  import wb_arb_pkg::*;
();

  localparam int CLK_PERIOD = 10;
  localparam int RST_CYCLES = 16;
  localparam int LATE_DELAY = 2;
  localparam int MASK_WAIT  = 24;
  localparam int GAP_CYCLES = 3;
  localparam int MAX_TESTS  = 32;

  logic                      wb_clk_i;
  logic                      wb_rst_i;
  logic    [NUM_MASTERS-1:0] wbm_cyc_i;
  logic    [NUM_MASTERS-1:0] wbm_stb_i;
  wb_req_t [NUM_MASTERS-1:0] wbm_req_i;
  logic    [NUM_MASTERS-1:0] wbm_mask_i;
  logic    [DATA_W-1:0]      wbm_dat_o;
  logic    [NUM_MASTERS-1:0] wbm_ack_o;
  logic    [NUM_MASTERS-1:0] wbm_err_o;
  logic    [MASTER_ID_W-1:0] wbm_id_o;

  // Test table as read from the stimulus file
  logic [NUM_MASTERS-1:0]       t_req   [MAX_TESTS];
  logic [NUM_MASTERS-1:0]       t_late  [MAX_TESTS];
  logic [NUM_MASTERS-1:0]       t_mask  [MAX_TESTS];
  logic [NUM_MASTERS-1:0]       t_we    [MAX_TESTS];
  logic [SEL_W*NUM_MASTERS-1:0] t_sel   [MAX_TESTS];
  logic [ADDR_W-1:0]            t_adr   [MAX_TESTS][NUM_MASTERS];
  logic [4*NUM_MASTERS-1:0]     t_order [MAX_TESTS];
  logic [NUM_MASTERS-1:0]       t_err   [MAX_TESTS];

  logic [DATA_W-1:0]      model [REG_WORDS];
  logic [15:0]            lfsr_state;
  logic [NUM_MASTERS-1:0] last_resp;
  int                     num_tests;
  int                     error_count;
  int                     failed_tests;
  int                     budget_cycles = 0;

  wb_arb_top wb_arb_top_i (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .wbm_cyc_i  (wbm_cyc_i),
    .wbm_stb_i  (wbm_stb_i),
    .wbm_req_i  (wbm_req_i),
    .wbm_mask_i (wbm_mask_i),
    .wbm_dat_o  (wbm_dat_o),
    .wbm_ack_o  (wbm_ack_o),
    .wbm_err_o  (wbm_err_o),
    .wbm_id_o   (wbm_id_o)
  );

  initial wb_clk_i = 1'b0;
  always #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;

  // Galois form of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hb400;
    end else begin
      return s >> 1;
    end
  endfunction

  task automatic random_word(output logic [DATA_W-1:0] w);
    w = '0;
    for (int k = 0; k < DATA_W; k++) begin
      w = {w[DATA_W-2:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                    input logic [DATA_W-1:0] new_w,
                                                    input logic [SEL_W-1:0]  sel);
    logic [DATA_W-1:0] w;
    w = old_w;
    for (int b = 0; b < SEL_W; b++) begin
      if (sel[b]) begin
        w[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return w;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] got_v);
    $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, exp_v, got_v);
    error_count++;
  endtask

  // A response may never last two cycles in a row
  task automatic check_held(input logic [NUM_MASTERS-1:0] resp);
    if (resp != '0 && last_resp != '0) begin
      $display("Error at %0t: response held for two cycles", $time);
      error_count++;
    end
    last_resp = resp;
  endtask

  task automatic load_tests();
    int    fd;
    int    n;
    string line;
    fd = $fopen("testbench/wb_arb_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Error: cannot open testbench/wb_arb_stimulus.txt");
      error_count++;
    end else begin
      while (!$feof(fd) && num_tests < MAX_TESTS) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                      t_req[num_tests], t_late[num_tests], t_mask[num_tests],
                      t_we[num_tests], t_sel[num_tests], t_adr[num_tests][0],
                      t_adr[num_tests][1], t_adr[num_tests][2], t_adr[num_tests][3],
                      t_order[num_tests], t_err[num_tests]);
          if (n == 11) begin
            num_tests++;
          end
        end
      end
      $fclose(fd);
      if (num_tests == 0) begin
        $display("Error: the stimulus file holds no tests");
        error_count++;
      end
    end
  endtask

  task automatic run_test(input int t);
    int                     n;
    int                     served;
    int                     cycle;
    int                     wait_count;
    int                     errs_before;
    int                     exp_id;
    int                     wd;
    logic [NUM_MASTERS-1:0] resp;
    logic [NUM_MASTERS-1:0] onehot;
    logic [NUM_MASTERS-1:0] active;
    logic [DATA_W-1:0]      wdat;
    logic [MASTER_ID_W-1:0] prev_id;
    wb_req_t                r;
    n = $countones(t_req[t] | t_late[t]);
    served = 0;
    cycle = 0;
    wait_count = 0;
    errs_before = error_count;
    @(posedge wb_clk_i);
    for (int i = 0; i < NUM_MASTERS; i++) begin
      random_word(wdat);
      r.we  = t_we[t][i];
      r.sel = t_sel[t][SEL_W*i +: SEL_W];
      r.adr = t_adr[t][i];
      r.dat = wdat;
      wbm_req_i[i] <= r;
    end
    active = t_req[t];
    wbm_mask_i <= t_mask[t];
    wbm_cyc_i  <= active;
    wbm_stb_i  <= active;
    prev_id = wbm_id_o;
    while (served < n) begin
      @(posedge wb_clk_i);
      cycle++;
      resp = wbm_ack_o | wbm_err_o;
      check_held(resp);
      if (resp != '0) begin
        exp_id = t_order[t][4*(n-1-served) +: 4];
        onehot = '0;
        onehot[exp_id] = 1'b1;
        if (resp != onehot) begin
          report_mismatch("wbm_ack_o|wbm_err_o", onehot, resp);
        end
        if (wbm_id_o != exp_id) begin
          report_mismatch("wbm_id_o", exp_id, wbm_id_o);
        end
        if (wbm_id_o != prev_id) begin
          $display("Error at %0t: grant changed in the cycle before the response", $time);
          error_count++;
        end
        if (wbm_err_o[exp_id] != t_err[t][exp_id]) begin
          report_mismatch("wbm_err_o", t_err[t][exp_id], wbm_err_o[exp_id]);
        end
        if (wbm_ack_o[exp_id] == t_err[t][exp_id]) begin
          report_mismatch("wbm_ack_o", !t_err[t][exp_id], wbm_ack_o[exp_id]);
        end
        wd = t_adr[t][exp_id][REG_IDX_W:1];
        if (!t_err[t][exp_id]) begin
          if (t_we[t][exp_id]) begin
            model[wd] = merge_bytes(model[wd], wbm_req_i[exp_id].dat,
                                    t_sel[t][SEL_W*exp_id +: SEL_W]);
          end else if (wbm_dat_o != model[wd]) begin
            report_mismatch("wbm_dat_o", model[wd], wbm_dat_o);
          end
        end
        active = active & ~resp;
        served++;
      end
      // Masked masters stay silent for a while before their mask bit opens
      if (served < n && served == $countones((t_req[t] | t_late[t]) & t_mask[t])) begin
        wait_count++;
        if (wait_count == MASK_WAIT) begin
          wbm_mask_i <= '1;
        end
      end
      if (cycle == LATE_DELAY) begin
        active = active | t_late[t];
      end
      wbm_cyc_i <= active;
      wbm_stb_i <= active;
      prev_id = wbm_id_o;
    end
    repeat (GAP_CYCLES) begin
      @(posedge wb_clk_i);
      resp = wbm_ack_o | wbm_err_o;
      check_held(resp);
      if (resp != '0) begin
        $display("Error at %0t: response %b after test %0d had finished", $time, resp, t);
        error_count++;
      end
    end
    if (error_count == errs_before) begin
      $display("Test %0d: ok, %0d requests served", t, n);
    end else begin
      $display("Test %0d: %0d errors", t, error_count - errs_before);
      failed_tests++;
    end
  endtask

  initial begin
    int budget;
    wb_rst_i     = 1'b1;
    wbm_cyc_i    = '0;
    wbm_stb_i    = '0;
    wbm_req_i    = '0;
    wbm_mask_i   = '0;
    lfsr_state   = 16'd29;
    last_resp    = '0;
    num_tests    = 0;
    error_count  = 0;
    failed_tests = 0;
    for (int i = 0; i < REG_WORDS; i++) begin
      model[i] = '0;
    end
    load_tests();
    budget = RST_CYCLES + 4;
    for (int t = 0; t < num_tests; t++) begin
      budget += $countones(t_req[t] | t_late[t]) * (TIMEOUT_CYCLES + 8);
      budget += GAP_CYCLES + LATE_DELAY + ((t_mask[t] != '1) ? MASK_WAIT : 0);
    end
    budget_cycles = budget;
    repeat (RST_CYCLES) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("Tests run: %0d, failed: %0d, errors: %0d", num_tests, failed_tests, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    wait (budget_cycles > 0);
    #(budget_cycles * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, a master never got its response",
             budget_cycles);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: verilog/wb_arb_fsm.sv
`timescale 1ns/1ps

module wb_arb_fsm
  import wb_arb_pkg::*;
(
  input  logic                   wb_clk_i,
  input  logic                   wb_rst_i,
  input  logic                   any_i,
  input  logic [MASTER_ID_W-1:0] pick_i,
  input  logic                   done_i,
  output logic [MASTER_ID_W-1:0] grant_o,
  output logic                   cyc_o,
  output logic                   clear_o
);

  arb_state_e state;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state   <= ARB_IDLE;
      grant_o <= '0;
      cyc_o   <= 1'b0;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (any_i) begin
            grant_o <= pick_i;
            cyc_o   <= 1'b1;
            state   <= ARB_BUSY;
          end
        end
        ARB_BUSY: begin
          // Ack or error ends the cycle, the master drops its request on this edge
          if (done_i) begin
            cyc_o <= 1'b0;
            state <= ARB_RELEASE;
          end
        end
        ARB_RELEASE: begin
          state <= ARB_IDLE;
        end
        default: begin
          cyc_o <= 1'b0;
          state <= ARB_IDLE;
        end
      endcase
    end
  end

  // Grant still points at the finished master during release
  assign clear_o = (state == ARB_RELEASE);

endmodule

// File: verilog/wb_arb_mux.sv
`timescale 1ns/1ps

module wb_arb_mux
  import wb_arb_pkg::*;
(
  input  logic    [MASTER_ID_W-1:0] grant_i,
  input  wb_req_t [NUM_MASTERS-1:0] req_i,
  output wb_req_t                   slv_req_o,
  input  wb_rsp_t                   slv_rsp_i,
  input  logic                      timeout_i,
  output logic    [DATA_W-1:0]      dat_o,
  output logic    [NUM_MASTERS-1:0] ack_o,
  output logic    [NUM_MASTERS-1:0] err_o
);

  assign slv_req_o = req_i[grant_i];

  // Read data is shared, only the granted master looks at it
  assign dat_o = slv_rsp_i.dat;

  always_comb begin
    ack_o = '0;
    err_o = '0;
    ack_o[grant_i] = slv_rsp_i.ack;
    err_o[grant_i] = slv_rsp_i.err | timeout_i;
  end

endmodule

// File: verilog/wb_arb_pending.sv
`timescale 1ns/1ps

module wb_arb_pending
  import wb_arb_pkg::*;
(
  input  logic                   wb_clk_i,
  input  logic                   wb_rst_i,
  input  logic [NUM_MASTERS-1:0] req_i,
  input  logic                   clear_i,
  input  logic [MASTER_ID_W-1:0] clear_id_i,
  output logic                   any_o,
  output logic [MASTER_ID_W-1:0] pick_o
);

  logic [NUM_MASTERS-1:0] pending;
  logic [NUM_MASTERS-1:0] pending_next;

  // New requests are ORed in, then the finished master's bit is knocked out
  always_comb begin
    pending_next = pending | req_i;
    if (clear_i) begin
      pending_next[clear_id_i] = 1'b0;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      pending <= '0;
    end else begin
      pending <= pending_next;
    end
  end

  assign any_o = |pending;

  // Fixed priority, the highest pending index wins
  always_comb begin
    pick_o = '0;
    for (int i = 0; i < NUM_MASTERS; i++) begin
      if (pending[i]) begin
        pick_o = MASTER_ID_W'(i);
      end
    end
  end

endmodule

// File: verilog/wb_arb_pkg.sv
package wb_arb_pkg;

  // Bus geometry
  localparam int DATA_W = 16;
  localparam int ADDR_W = 32;
  localparam int SEL_W  = DATA_W / 8;

  // Arbiter sizing
  localparam int NUM_MASTERS = 4;
  localparam int MASTER_ID_W = 2;

  // Bus timer
  localparam int TIMEOUT_CYCLES = 16;
  localparam int TIMER_W        = 5;

  // Register file slave, word index taken from address bits 1 to 4
  localparam int REG_WORDS = 16;
  localparam int REG_IDX_W = 4;

  // One master's request as seen by the slave
  typedef struct packed {
    logic              we;
    logic [SEL_W-1:0]  sel;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat;
  } wb_req_t;

  // Slave response
  typedef struct packed {
    logic [DATA_W-1:0] dat;
    logic              ack;
    logic              err;
  } wb_rsp_t;

  typedef enum logic [1:0] {
    ARB_IDLE    = 2'd0,
    ARB_BUSY    = 2'd1,
    ARB_RELEASE = 2'd2
  } arb_state_e;

endpackage

// File: verilog/wb_arb_top.sv
`timescale 1ns/1ps

module wb_arb_top
  import wb_arb_pkg::*;
(
  input  logic                      wb_clk_i,
  input  logic                      wb_rst_i,
  input  logic    [NUM_MASTERS-1:0] wbm_cyc_i,
  input  logic    [NUM_MASTERS-1:0] wbm_stb_i,
  input  wb_req_t [NUM_MASTERS-1:0] wbm_req_i,
  input  logic    [NUM_MASTERS-1:0] wbm_mask_i,
  output logic    [DATA_W-1:0]      wbm_dat_o,
  output logic    [NUM_MASTERS-1:0] wbm_ack_o,
  output logic    [NUM_MASTERS-1:0] wbm_err_o,
  output logic    [MASTER_ID_W-1:0] wbm_id_o
);

  logic [NUM_MASTERS-1:0] req_masked;
  logic                   pend_any;
  logic [MASTER_ID_W-1:0] pend_pick;
  logic                   pend_clear;
  logic                   done;
  logic                   slv_cyc;
  wb_req_t                slv_req;
  wb_rsp_t                slv_rsp;
  logic                   timeout;

  assign req_masked = wbm_cyc_i & wbm_stb_i & wbm_mask_i;
  assign done       = |(wbm_ack_o | wbm_err_o);

  wb_arb_pending pending_i (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .req_i      (req_masked),
    .clear_i    (pend_clear),
    .clear_id_i (wbm_id_o),
    .any_o      (pend_any),
    .pick_o     (pend_pick)
  );

  wb_arb_fsm fsm_i (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .any_i    (pend_any),
    .pick_i   (pend_pick),
    .done_i   (done),
    .grant_o  (wbm_id_o),
    .cyc_o    (slv_cyc),
    .clear_o  (pend_clear)
  );

  wb_arb_mux mux_i (
    .grant_i   (wbm_id_o),
    .req_i     (wbm_req_i),
    .slv_req_o (slv_req),
    .slv_rsp_i (slv_rsp),
    .timeout_i (timeout),
    .dat_o     (wbm_dat_o),
    .ack_o     (wbm_ack_o),
    .err_o     (wbm_err_o)
  );

  wb_bus_timer timer_i (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .cyc_i     (slv_cyc),
    .ack_i     (slv_rsp.ack),
    .timeout_o (timeout)
  );

  wb_reg_slave slave_i (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .cyc_i    (slv_cyc),
    .req_i    (slv_req),
    .rsp_o    (slv_rsp)
  );

endmodule

// File: verilog/wb_bus_timer.sv
`timescale 1ns/1ps

module wb_bus_timer
  import wb_arb_pkg::*;
(
  input  logic wb_clk_i,
  input  logic wb_rst_i,
  input  logic cyc_i,
  input  logic ack_i,
  output logic timeout_o
);

  logic [TIMER_W-1:0] count;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      count     <= '0;
      timeout_o <= 1'b0;
    end else if (!cyc_i || ack_i) begin
      count     <= '0;
      timeout_o <= 1'b0;
    end else begin
      count <= count + 1'b1;
      // Count runs past the limit while cyc is still high, so this fires once
      timeout_o <= (count == TIMER_W'(TIMEOUT_CYCLES - 1));
    end
  end

endmodule

// File: verilog/wb_reg_slave.sv
`timescale 1ns/1ps

module wb_reg_slave
  import wb_arb_pkg::*;
(
  input  logic    wb_clk_i,
  input  logic    wb_rst_i,
  input  logic    cyc_i,
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o
);

  logic [DATA_W-1:0]    regs [REG_WORDS];
  logic [REG_IDX_W-1:0] idx;
  logic                 in_range;
  logic                 access;
  logic                 ack_q;
  logic [DATA_W-1:0]    rdat_q;

  // Bit 0 is the byte lane, anything above the word index is out of range
  assign idx      = req_i.adr[REG_IDX_W:1];
  assign in_range = (req_i.adr[ADDR_W-1:REG_IDX_W+1] == '0);
  assign access   = cyc_i && in_range && !ack_q;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
      for (int i = 0; i < REG_WORDS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      ack_q <= access;
      if (access && req_i.we) begin
        for (int b = 0; b < SEL_W; b++) begin
          if (req_i.sel[b]) begin
            regs[idx][b*8 +: 8] <= req_i.dat[b*8 +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (access && !req_i.we) begin
      rdat_q <= regs[idx];
    end
  end

  // Errors come from the bus timer, the slave never flags one itself
  assign rsp_o = '{dat: rdat_q, ack: ack_q, err: 1'b0};

endmodule
